// File: list.f
stats_pkg.sv
stat_stream_if.sv
stats_collect.sv
stats_counter.sv
stats_regs.sv
stats_top.sv
tb_stats_top.sv

// File: Bender.yml
package:
  name: stats_subsystem

sources:
  - stats_pkg.sv
  - stat_stream_if.sv
  - stats_collect.sv
  - stats_counter.sv
  - stats_regs.sv
  - stats_top.sv
  - target: simulation
    files:
      - tb_stats_top.sv

// File: tb_stats_top.sv
// Runs with 8 channels and a 64-cycle sweep period; stops at the first mismatch.
`timescale 1ns/1ns

module tb_stats_top;

    localparam int cnt = 8;
    localparam int inc_w = 8;
    localparam int update_period = 64;
    localparam int flush_wait = 4 * cnt + 20;
    localparam int read_sweep = (cnt + 1) * 4;
    localparam int run_cycles = 3 + 20 + 400 + 200 + 300 + 4 * flush_wait + update_period
        + 8 * read_sweep + 200;

    typedef logic [stats_pkg::reg_addr_w-1:0] addr_t;

    logic                             clk;
    logic                             rst;
    logic [inc_w-1:0]                 stat_inc [cnt];
    logic                             stat_valid [cnt];
    logic                             reg_wr;
    logic                             reg_rd;
    addr_t                            reg_addr;
    logic [stats_pkg::stat_w-1:0]     reg_wdata;
    logic [stats_pkg::stat_w-1:0]     reg_rdata;
    logic                             reg_rvalid;

    logic [31:0] model [cnt];
    logic [31:0] rng;
    logic [31:0] rd_val;
    int          reads_issued;
    int          responses;

    stats_top #(
        .cnt(cnt),
        .inc_w(inc_w),
        .update_period(update_period)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .stat_inc(stat_inc),
        .stat_valid(stat_valid),
        .reg_wr(reg_wr),
        .reg_rd(reg_rd),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .reg_rvalid(reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (!rst && reg_rvalid) begin
            responses++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Every read must answer exactly 3 cycles after reg_rd.
    task automatic read_reg(input addr_t addr, output logic [31:0] data);
        int lat;
        @(posedge clk);
        reg_rd <= 1'b1;
        reg_addr <= addr;
        reads_issued++;
        lat = 0;
        do begin
            @(posedge clk);
            reg_rd <= 1'b0;
            lat++;
            @(negedge clk);
        end while (!reg_rvalid && lat < 16);
        if (!reg_rvalid) begin
            $display("read of address %0d got no response", addr);
            $display("tests failed");
            $fatal(1);
        end
        check_equal($sformatf("read latency at address %0d", addr), 3, lat);
        data = reg_rdata;
    endtask

    task automatic write_ctrl(input logic [31:0] value);
        @(posedge clk);
        reg_wr <= 1'b1;
        reg_addr <= stats_pkg::reg_ctrl_addr;
        reg_wdata <= value;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // Random increments; optionally counter reads on every cycle as well.
    task automatic drive_traffic(input int cycles, input bit with_reads);
        int rd_idx;
        rd_idx = 0;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            for (int i = 0; i < cnt; i++) begin
                rng = xorshift32(rng);
                stat_valid[i] <= rng[8];
                stat_inc[i] <= rng[7:0];
                if (rng[8]) begin
                    model[i] = model[i] + 32'(rng[7:0]);
                end
            end
            if (with_reads) begin
                reg_rd <= 1'b1;
                reg_addr <= stats_pkg::reg_cnt_base + addr_t'(rd_idx);
                reads_issued++;
                rd_idx = (rd_idx + 1) % cnt;
            end
        end
        @(posedge clk);
        for (int i = 0; i < cnt; i++) begin
            stat_valid[i] <= 1'b0;
        end
        reg_rd <= 1'b0;
    endtask

    task automatic check_all_counters(input string name);
        for (int i = 0; i < cnt; i++) begin
            read_reg(stats_pkg::reg_cnt_base + addr_t'(i), rd_val);
            check_equal($sformatf("%s counter %0d", name, i), model[i], rd_val);
        end
    endtask

    initial begin
        #(run_cycles * 20);
        $display("timeout: the run did not finish within %0d cycles", run_cycles);
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        rng = 32'h2827_5d82;
        reads_issued = 0;
        responses = 0;
        for (int i = 0; i < cnt; i++) begin
            stat_inc[i] = '0;
            stat_valid[i] = 1'b0;
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Counter memory clears itself first.
        repeat (20) @(posedge clk);

        read_reg(stats_pkg::reg_ctrl_addr, rd_val);
        check_equal("reset control", 32'h0, rd_val);
        check_all_counters("reset");

        drive_traffic(400, 1'b0);
        write_ctrl(32'h1 << stats_pkg::ctrl_flush_bit);
        repeat (flush_wait) @(posedge clk);
        check_all_counters("flush");

        drive_traffic(200, 1'b0);
        repeat (update_period + flush_wait) @(posedge clk);
        check_all_counters("periodic");

        write_ctrl((32'h1 << stats_pkg::ctrl_cor_bit) | (32'h1 << stats_pkg::ctrl_flush_bit));
        repeat (flush_wait) @(posedge clk);
        read_reg(stats_pkg::reg_ctrl_addr, rd_val);
        check_equal("clear-on-read control", 32'h1 << stats_pkg::ctrl_cor_bit, rd_val);
        check_all_counters("clear-on-read first");
        for (int i = 0; i < cnt; i++) begin
            model[i] = '0;
        end
        check_all_counters("clear-on-read second");
        write_ctrl(32'h0);

        drive_traffic(300, 1'b1);
        write_ctrl(32'h1 << stats_pkg::ctrl_flush_bit);
        repeat (flush_wait) @(posedge clk);
        check_equal("contention read responses", reads_issued, responses);
        check_all_counters("contention");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: stats_top.sv
// Counters are cleared for cnt cycles after reset; host reads issued then get no response.
`timescale 1ns/1ns

module stats_top #(
    parameter int cnt = 8,
    parameter int inc_w = 8,
    parameter int update_period = 256
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [inc_w-1:0]                  stat_inc [cnt],
    input  logic                              stat_valid [cnt],
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [stats_pkg::reg_addr_w-1:0]  reg_addr,
    input  logic [stats_pkg::stat_w-1:0]      reg_wdata,
    output logic [stats_pkg::stat_w-1:0]      reg_rdata,
    output logic                              reg_rvalid
);

    logic                              flush;
    logic                              clear_on_read;
    logic                              cnt_rd;
    logic [stats_pkg::stat_id_w-1:0]   cnt_addr;
    logic [stats_pkg::stat_w-1:0]      cnt_rdata;
    logic                              cnt_rvalid;

    stat_stream_if u_stat_if ();

    stats_collect #(
        .cnt(cnt),
        .inc_w(inc_w),
        .update_period(update_period)
    ) u_collect (
        .clk(clk),
        .rst(rst),
        .stat_inc(stat_inc),
        .stat_valid(stat_valid),
        .flush(flush),
        .m_stat(u_stat_if.src)
    );

    stats_counter #(
        .cnt(cnt)
    ) u_counter (
        .clk(clk),
        .rst(rst),
        .s_stat(u_stat_if.dst),
        .clear_on_read(clear_on_read),
        .cnt_rd(cnt_rd),
        .cnt_addr(cnt_addr),
        .cnt_rdata(cnt_rdata),
        .cnt_rvalid(cnt_rvalid)
    );

    stats_regs #(
        .cnt(cnt)
    ) u_regs (
        .clk(clk),
        .rst(rst),
        .reg_wr(reg_wr),
        .reg_rd(reg_rd),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .reg_rvalid(reg_rvalid),
        .flush(flush),
        .clear_on_read(clear_on_read),
        .cnt_rd(cnt_rd),
        .cnt_addr(cnt_addr),
        .cnt_rdata(cnt_rdata),
        .cnt_rvalid(cnt_rvalid)
    );

endmodule

// File: stats_regs.sv
// Reads return after 3 cycles for every address; reg_wr and reg_rd must not overlap.
`timescale 1ns/1ns

module stats_regs #(
    parameter int cnt = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  logic [stats_pkg::reg_addr_w-1:0]  reg_addr,
    input  logic [stats_pkg::stat_w-1:0]      reg_wdata,
    output logic [stats_pkg::stat_w-1:0]      reg_rdata,
    output logic                              reg_rvalid,
    output logic                              flush,
    output logic                              clear_on_read,
    output logic                              cnt_rd,
    output logic [stats_pkg::stat_id_w-1:0]   cnt_addr,
    input  logic [stats_pkg::stat_w-1:0]      cnt_rdata,
    input  logic                              cnt_rvalid
);

    stats_pkg::reg_sel_e sel, sel_q, sel_d1, sel_d2;

    logic [2:0]                         rd_pipe;
    logic [stats_pkg::reg_addr_w-1:0]   cnt_offset;

    always_comb begin
        cnt_offset = reg_addr - stats_pkg::reg_cnt_base;
        if (reg_addr == stats_pkg::reg_ctrl_addr) begin
            sel = stats_pkg::sel_ctrl;
        end else if (reg_addr >= stats_pkg::reg_cnt_base && cnt_offset < cnt) begin
            sel = stats_pkg::sel_counter;
        end else begin
            sel = stats_pkg::sel_none;
        end
    end

    // Target follows the read down a 3-stage pipe.
    always_ff @(posedge clk) begin
        sel_q <= sel;
        sel_d1 <= sel_q;
        sel_d2 <= sel_d1;
        cnt_addr <= stats_pkg::stat_id_w'(cnt_offset);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pipe <= '0;
            cnt_rd <= 1'b0;
            flush <= 1'b0;
            clear_on_read <= 1'b0;
        end else begin
            rd_pipe <= {rd_pipe[1:0], reg_rd};
            cnt_rd <= reg_rd && sel == stats_pkg::sel_counter;
            flush <= reg_wr && sel == stats_pkg::sel_ctrl
                && reg_wdata[stats_pkg::ctrl_flush_bit];
            if (reg_wr && sel == stats_pkg::sel_ctrl) begin
                clear_on_read <= reg_wdata[stats_pkg::ctrl_cor_bit];
            end
        end
    end

    assign reg_rvalid = rd_pipe[2] && (sel_d2 != stats_pkg::sel_counter || cnt_rvalid);

    always_comb begin
        reg_rdata = '0;
        case (sel_d2)
            stats_pkg::sel_counter: reg_rdata = cnt_rdata;
            // Flush bit reads as 0.
            stats_pkg::sel_ctrl: reg_rdata[stats_pkg::ctrl_cor_bit] = clear_on_read;
            default: reg_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) !(reg_wr && reg_rd));

endmodule

// File: stats_counter.sv
// One shared read port with a separate write port; host reads take 2 cycles and stall the stream.
`timescale 1ns/1ns

module stats_counter #(
    parameter int cnt = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    stat_stream_if.dst                        s_stat,
    input  logic                              clear_on_read,
    input  logic                              cnt_rd,
    input  logic [stats_pkg::stat_id_w-1:0]   cnt_addr,
    output logic [stats_pkg::stat_w-1:0]      cnt_rdata,
    output logic                              cnt_rvalid
);

    localparam int cnt_w = cnt > 1 ? $clog2(cnt) : 1;

    typedef logic [stats_pkg::stat_w-1:0] word_t;

    word_t mem [cnt];

    logic             init;
    logic [cnt_w-1:0] init_addr;
    logic             accept;
    logic [cnt_w-1:0] rd_addr;
    word_t            rd_data;
    logic             upd_pend;
    logic             host_pend;
    logic             host_clear;
    logic             fwd;
    logic [cnt_w-1:0] s2_addr;
    word_t            s2_inc;
    word_t            last_wr;
    word_t            base;
    logic             wr_en;
    logic [cnt_w-1:0] wr_addr;
    word_t            wr_data;

    // Host read takes the read port.
    assign s_stat.ready = !init && !cnt_rd;
    assign accept = s_stat.valid && s_stat.ready;
    assign rd_addr = cnt_rd ? cnt_w'(cnt_addr) : cnt_w'(s_stat.id);

    // Bypass a write that landed in the read cycle.
    assign base = fwd ? last_wr : rd_data;

    always_comb begin
        wr_en = 1'b0;
        wr_addr = s2_addr;
        wr_data = base + s2_inc;
        if (init) begin
            wr_en = 1'b1;
            wr_addr = init_addr;
            wr_data = '0;
        end else if (upd_pend) begin
            wr_en = 1'b1;
        end else if (host_pend && host_clear) begin
            wr_en = 1'b1;
            wr_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rd || accept) begin
            rd_data <= mem[rd_addr];
        end
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
            last_wr <= wr_data;
        end
        if (host_pend) begin
            cnt_rdata <= base;
        end
        fwd <= wr_en && wr_addr == rd_addr;
        s2_addr <= rd_addr;
        s2_inc <= s_stat.data;
        host_clear <= clear_on_read;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init <= 1'b1;
            init_addr <= '0;
            upd_pend <= 1'b0;
            host_pend <= 1'b0;
            cnt_rvalid <= 1'b0;
        end else begin
            upd_pend <= accept;
            host_pend <= cnt_rd && !init;
            cnt_rvalid <= host_pend;
            if (init) begin
                init_addr <= init_addr + 1'b1;
                if (init_addr == cnt_w'(cnt - 1)) begin
                    init <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) accept |-> s_stat.id < cnt);

endmodule

// File: stats_collect.sv
// Needs cnt of at least 2; a flush or period request is served within 4*cnt cycles plus stalls.
`timescale 1ns/1ns

module stats_collect #(
    parameter int cnt = 8,
    parameter int inc_w = 8,
    parameter int update_period = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [inc_w-1:0] stat_inc [cnt],
    input  logic             stat_valid [cnt],
    input  logic             flush,
    stat_stream_if.src       m_stat
);

    localparam int cnt_w = cnt > 1 ? $clog2(cnt) : 1;
    localparam int acc_w = inc_w + cnt_w + 1;
    localparam int period_w = $clog2(update_period + 1);

    typedef logic [stats_pkg::stat_w-1:0] word_t;
    typedef logic [stats_pkg::stat_id_w-1:0] id_t;

    stats_pkg::collect_state_e state, state_next;

    logic [cnt_w-1:0]    count, count_next;
    logic [period_w-1:0] period_cnt, period_cnt_next;
    logic                first_round, first_round_next;
    logic                update_req, update_req_next;
    logic                update, update_next;
    logic [cnt-1:0]      owe_shift, owe_shift_next;

    word_t out_data, out_data_next;
    id_t   out_id, out_id_next;
    logic  out_valid, out_valid_next;

    logic [acc_w-1:0] acc [cnt];
    logic [cnt-1:0]   acc_clear;

    word_t hold_mem [cnt];
    word_t hold_rd;
    word_t hold_wr_data;
    word_t total;
    logic  hold_rd_en;
    logic  hold_wr_en;
    logic  owed;

    assign m_stat.data = out_data;
    assign m_stat.id = out_id;
    assign m_stat.valid = out_valid;

    // Holding memory is undefined until the first round has written it.
    assign total = (first_round ? word_t'(0) : hold_rd) + word_t'(acc[count]);
    assign owed = update || owe_shift[0];

    for (genvar i = 0; i < cnt; i++) begin : g_acc
        always_ff @(posedge clk) begin
            if (rst) begin
                acc[i] <= '0;
            end else if (acc_clear[i]) begin
                // Restart from the increment arriving in the same cycle.
                acc[i] <= stat_valid[i] ? acc_w'(stat_inc[i]) : '0;
            end else if (stat_valid[i]) begin
                acc[i] <= acc[i] + acc_w'(stat_inc[i]);
            end
        end
    end

    always_comb begin
        state_next = state;
        count_next = count;
        period_cnt_next = period_cnt;
        first_round_next = first_round;
        update_req_next = update_req;
        update_next = update;
        owe_shift_next = owe_shift;
        out_data_next = out_data;
        out_id_next = out_id;
        out_valid_next = out_valid && !m_stat.ready;
        acc_clear = '0;
        hold_rd_en = 1'b0;
        hold_wr_en = 1'b0;
        hold_wr_data = total;

        case (state)
            stats_pkg::collect_read: begin
                hold_rd_en = 1'b1;
                state_next = stats_pkg::collect_write;
            end
            stats_pkg::collect_write: begin
                hold_wr_en = 1'b1;
                acc_clear[count] = 1'b1;
                owe_shift_next = {owed, owe_shift[cnt-1:1]};
                // Emit when owed and the output slot frees up; otherwise fold back.
                if (owed && (!out_valid || m_stat.ready)) begin
                    owe_shift_next[cnt-1] = 1'b0;
                    hold_wr_data = '0;
                    out_data_next = total;
                    out_id_next = id_t'(count);
                    out_valid_next = total != '0;
                end
                if (count == cnt_w'(cnt - 1)) begin
                    count_next = '0;
                    first_round_next = 1'b0;
                    update_req_next = 1'b0;
                    update_next = update_req;
                end else begin
                    count_next = count + 1'b1;
                end
                state_next = stats_pkg::collect_read;
            end
            default: state_next = stats_pkg::collect_read;
        endcase

        // Requests latch here and start at the next round.
        if (period_cnt == '0 || flush) begin
            update_req_next = 1'b1;
            period_cnt_next = period_w'(update_period - 1);
        end else begin
            period_cnt_next = period_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_wr_en) begin
            hold_mem[count] <= hold_wr_data;
        end else if (hold_rd_en) begin
            hold_rd <= hold_mem[count];
        end
        out_data <= out_data_next;
        out_id <= out_id_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stats_pkg::collect_read;
            count <= '0;
            period_cnt <= period_w'(update_period - 1);
            first_round <= 1'b1;
            update_req <= 1'b0;
            update <= 1'b0;
            owe_shift <= '0;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            period_cnt <= period_cnt_next;
            first_round <= first_round_next;
            update_req <= update_req_next;
            update <= update_next;
            owe_shift <= owe_shift_next;
            out_valid <= out_valid_next;
        end
    end

    assert property (@(posedge clk) disable iff (rst) m_stat.valid |-> m_stat.id < cnt);

    // Stalled word stays put until the counter takes it.
    assert property (@(posedge clk) disable iff (rst)
        m_stat.valid && !m_stat.ready |=> m_stat.valid && $stable(m_stat.data)
            && $stable(m_stat.id));

endmodule

// File: stat_stream_if.sv
// Carries no clock; both ends must sample on the same clock, one word per valid/ready beat.
`timescale 1ns/1ns

interface stat_stream_if;

    logic [stats_pkg::stat_w-1:0]    data;
    logic [stats_pkg::stat_id_w-1:0] id;
    logic                            valid;
    logic                            ready;

    // Source holds data and id until ready.
    modport src (
        output data,
        output id,
        output valid,
        input  ready
    );

    modport dst (
        input  data,
        input  id,
        input  valid,
        output ready
    );

endinterface

// File: stats_pkg.sv
// Widths fix the limits: at most 256 channels, 32-bit counters, 9-bit host address.
package stats_pkg;

    // Stream and counter word.
    localparam int stat_w = 32;
    localparam int stat_id_w = 8;

    // Host register map.
    localparam int reg_addr_w = 9;
    localparam logic [reg_addr_w-1:0] reg_ctrl_addr = 9'd0;
    localparam logic [reg_addr_w-1:0] reg_cnt_base = 9'd1;

    // Control register bits.
    localparam int ctrl_flush_bit = 0;
    localparam int ctrl_cor_bit = 1;

    // Sweep phases of the collector.
    typedef enum logic {
        collect_read,
        collect_write
    } collect_state_e;

    // Host access target.
    typedef enum logic [1:0] {
        sel_none,
        sel_ctrl,
        sel_counter
    } reg_sel_e;

endpackage
